/* Makefile */
# Verilator simulation of the video output stage

VERILATOR ?= verilator
TOP       ?= tb_video_output
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* debug_overlay.sv */
`timescale 1ns/10ps
`default_nettype none

module debug_overlay (
  input  wire                       CLK_VIDEO,
  input  wire                       core_sreset,
  input  wire                       pc_write_i,
  input  wire [31:0]                pc_data_i,
  input  wire [7:0]                 player_i,
  input  wire                       debug_i,
  input  wire video_pkg::video_timing_t timing_i,
  output logic                      active_o,
  output logic [7:0]                level_o
);

  debug_pkg::debug_value_t                  captured;
  logic [debug_pkg::DEBUG_VALUE_W-1:0]      value_bits;
  logic [debug_pkg::DEBUG_BIT_W-1:0]        bit_sel;
  logic                                     flag_strobe;

  // Strobe carrying a non-zero flag byte
  assign flag_strobe = pc_write_i && (pc_data_i[31:24] != 8'h00);

  //////////////////////////////////////////////////
  // Capture
  //////////////////////////////////////////////////

  always_ff @(posedge CLK_VIDEO) begin
    if (core_sreset) begin
      captured <= '0;
    end else begin
      if (pc_write_i) begin
        captured.pc <= pc_data_i[23:0];
      end
      // Error flag wins, else live player inputs
      if (flag_strobe) begin
        captured.flags <= debug_pkg::OVERLAY_ON;
      end else begin
        captured.flags <= player_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // Drawing
  //////////////////////////////////////////////////

  assign value_bits = captured;

  // MSB on the left, two pixels per bit
  assign bit_sel = debug_pkg::DEBUG_BIT_W'(debug_pkg::DEBUG_VALUE_W - 1)
                 - debug_pkg::DEBUG_BIT_W'(timing_i.hcount / debug_pkg::OVERLAY_PIXELS_PER_BIT);

  assign active_o = debug_i
                 && (timing_i.hcount < 9'(debug_pkg::OVERLAY_WIDTH))
                 && (timing_i.vcount < 9'(debug_pkg::OVERLAY_HEIGHT));

  assign level_o = value_bits[bit_sel] ? debug_pkg::OVERLAY_ON : debug_pkg::OVERLAY_OFF;

endmodule

`default_nettype wire

/* debug_pkg.sv */
`default_nettype none

package debug_pkg;

  //////////////////////////////////////////////////
  // Debug overlay window
  //////////////////////////////////////////////////

  localparam int OVERLAY_WIDTH          = 64;
  localparam int OVERLAY_HEIGHT         = 10;
  localparam int OVERLAY_PIXELS_PER_BIT = 2;

  // Channel levels for set and clear bits
  localparam logic [7:0] OVERLAY_ON  = 8'hFF;
  localparam logic [7:0] OVERLAY_OFF = 8'h00;

  localparam int DEBUG_VALUE_W = 32;
  localparam int DEBUG_BIT_W   = $clog2(DEBUG_VALUE_W);

  // Captured value, flag or player byte on top of the PC
  typedef struct packed {
    logic [7:0]  flags;
    logic [23:0] pc;
  } debug_value_t;

endpackage

`default_nettype wire

/* pixel_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_fifo (
  input  wire                    CLK_VIDEO,
  input  wire                    core_sreset,
  input  wire video_pkg::fifo_word_t word_i,
  input  wire                    write_i,
  input  wire                    pop_i,
  output video_pkg::pixel555_t   head_pixel_o,
  output logic                   empty_o,
  output logic                   ready_o
);

  // Word storage
  video_pkg::fifo_word_t mem [video_pkg::FIFO_DEPTH_WORDS];

  logic [video_pkg::FIFO_PTR_W-1:0]   wr_ptr;
  logic [video_pkg::FIFO_PTR_W-1:0]   rd_ptr;
  logic [video_pkg::FIFO_COUNT_W-1:0] count;
  // Pixel position inside the head word
  logic [video_pkg::PIX_IDX_W-1:0]    pix_idx;
  logic                               word_done;

  // Last pixel of the head word leaves this cycle
  assign word_done = pop_i && (pix_idx == video_pkg::PIX_IDX_W'(video_pkg::PIXELS_PER_WORD - 1));

  // Show-ahead head pixel
  assign head_pixel_o = mem[rd_ptr][pix_idx];
  assign empty_o      = (count == '0);
  // Combinational from the current fill level
  assign ready_o      = (count < video_pkg::FIFO_COUNT_W'(video_pkg::FIFO_READY_LIMIT));

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  always_ff @(posedge CLK_VIDEO) begin
    if (write_i) begin
      mem[wr_ptr] <= word_i;
    end
  end

  always_ff @(posedge CLK_VIDEO) begin
    if (core_sreset) begin
      wr_ptr <= '0;
    end else if (write_i) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Read side and fill level
  //////////////////////////////////////////////////

  always_ff @(posedge CLK_VIDEO) begin
    if (core_sreset) begin
      rd_ptr  <= '0;
      pix_idx <= '0;
      count   <= '0;
    end else begin
      if (pop_i) begin
        // Wraps to the first pixel of the next word
        pix_idx <= pix_idx + 1'b1;
      end
      if (word_done) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Net change of stored words
      case ({write_i, word_done})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Reader must honour ready, so the memory never overflows
  a_no_write_full: assert property (@(posedge CLK_VIDEO) disable iff (core_sreset)
    write_i |-> (count < video_pkg::FIFO_COUNT_W'(video_pkg::FIFO_DEPTH_WORDS)))
    else $error("pixel_fifo write while full");

  // Lock controller must never pop an empty FIFO
  a_no_pop_empty: assert property (@(posedge CLK_VIDEO) disable iff (core_sreset)
    pop_i |-> !empty_o)
    else $error("pixel_fifo pop while empty");

endmodule

`default_nettype wire

/* pixel_out_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_out_stage (
  input  wire                       CLK_VIDEO,
  input  wire                       core_sreset,
  input  wire video_pkg::video_timing_t timing_i,
  input  wire video_pkg::pixel555_t   pixel_i,
  input  wire                       show_pixel_i,
  input  wire                       overlay_active_i,
  input  wire [7:0]                 overlay_level_i,
  output video_pkg::rgb888_t        rgb_o,
  output logic                      hsync_o,
  output logic                      vsync_o,
  output logic                      de_o
);

  video_pkg::rgb888_t color_next;

  //////////////////////////////////////////////////
  // Color select
  //////////////////////////////////////////////////

  always_comb begin
    if (overlay_active_i) begin
      // Grey level from the overlay bit
      color_next.red   = overlay_level_i;
      color_next.green = overlay_level_i;
      color_next.blue  = overlay_level_i;
    end else if (show_pixel_i) begin
      // 5 to 8 bits, top three bits repeated
      color_next.red   = {pixel_i.red, pixel_i.red[4:2]};
      color_next.green = {pixel_i.green, pixel_i.green[4:2]};
      color_next.blue  = {pixel_i.blue, pixel_i.blue[4:2]};
    end else begin
      // Underrun or blanking
      color_next = '0;
    end
  end

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  always_ff @(posedge CLK_VIDEO) begin
    if (core_sreset) begin
      rgb_o   <= '0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
    end else begin
      rgb_o   <= color_next;
      // Syncs delayed to line up with color
      hsync_o <= timing_i.hsync;
      vsync_o <= timing_i.vsync;
      de_o    <= timing_i.de;
    end
  end

endmodule

`default_nettype wire

/* scan_lock_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module scan_lock_ctrl (
  input  wire                       CLK_VIDEO,
  input  wire                       core_sreset,
  input  wire video_pkg::video_timing_t timing_i,
  input  wire                       empty_i,
  output logic                      pop_o,
  output logic                      show_pixel_o
);

  // Set once at the first frame start with data
  logic locked;
  logic lock_start;
  logic consume;

  // Both blanks high means we sit between frames
  assign lock_start = timing_i.hblank && timing_i.vblank && !empty_i;

  // Head pixel is used up on every displayed cycle
  // once locked and fed
  assign consume = timing_i.de && locked && !empty_i;

  assign pop_o        = consume;
  assign show_pixel_o = consume;

  //////////////////////////////////////////////////
  // Lock flag
  //////////////////////////////////////////////////

  always_ff @(posedge CLK_VIDEO) begin
    if (core_sreset) begin
      locked <= 1'b0;
    end else if (lock_start) begin
      // Sticky until reset
      locked <= 1'b1;
    end
  end

  // Display enable must stay out of blanking so pops follow the beam
  a_pop_in_display: assert property (@(posedge CLK_VIDEO) disable iff (core_sreset)
    pop_o |-> (!timing_i.hblank && !timing_i.vblank))
    else $error("scan_lock_ctrl pop during blanking");

endmodule

`default_nettype wire

/* src.f */
video_pkg.sv
debug_pkg.sv
pixel_fifo.sv
scan_lock_ctrl.sv
debug_overlay.sv
pixel_out_stage.sv
video_output_top.sv
tb_video_output.sv

/* tb_video_output.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_video_output;

  //////////////////////////////////////////////////
  // Clock, reset and line format
  //////////////////////////////////////////////////

  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 8;
  // 72 shown pixels, 12 blank, sync inside the blank
  localparam logic [8:0] H_ACTIVE     = 9'd72;
  localparam logic [8:0] H_TOTAL      = 9'd84;
  localparam logic [8:0] H_SYNC_START = 9'd76;
  localparam logic [8:0] H_SYNC_END   = 9'd80;
  // 12 shown lines, 2 blank lines
  localparam logic [8:0] V_ACTIVE     = 9'd12;
  localparam logic [8:0] V_SYNC_LINE  = 9'd12;
  // Lines over all tests, reset and idle cycles, then a margin
  localparam int RUN_LINES       = 60;
  localparam int RUN_CYCLES      = RESET_CYCLES + 4 + RUN_LINES * int'(H_TOTAL);
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + 500;

  logic                     CLK_VIDEO = 1'b0;
  logic                     core_sreset;
  video_pkg::video_timing_t timing_i;
  video_pkg::fifo_word_t    word_i;
  logic                     word_write_i;
  logic                     pc_write_i;
  logic [31:0]              pc_data_i;
  logic [7:0]               player_i;
  logic                     debug_i;
  logic                     fifo_ready_o;
  video_pkg::rgb888_t       rgb_o;
  logic                     hsync_o;
  logic                     vsync_o;
  logic                     de_o;

  // Stimulus modes
  logic   reset_on      = 1'b1;
  logic   writer_on     = 1'b0;
  logic   debug_on      = 1'b0;
  logic   player_random = 1'b0;
  int     strobe_mode   = 0;
  integer seed          = 32'haf62_f8c7;

  // Reference model state
  logic [15:0]             pixel_q [$];
  logic                    locked_m   = 1'b0;
  debug_pkg::debug_value_t captured_m = '0;
  // Expected values of the current cycle, then one cycle later
  logic                    model_valid       = 1'b0;
  logic                    model_ready_valid = 1'b0;
  logic                    model_ready       = 1'b1;
  video_pkg::rgb888_t      model_rgb         = '0;
  logic [2:0]              model_ctrl        = '0;
  logic                    exp_valid         = 1'b0;
  video_pkg::rgb888_t      exp_rgb           = '0;
  logic [2:0]              exp_ctrl          = '0;

  // Bookkeeping
  string test_name = "startup";
  int    error_count       = 0;
  int    test_start_errors = 0;
  int    tests_run         = 0;
  int    tests_passed      = 0;

  video_output_top DUT (
    .CLK_VIDEO    (CLK_VIDEO),
    .core_sreset  (core_sreset),
    .timing_i     (timing_i),
    .word_i       (word_i),
    .word_write_i (word_write_i),
    .fifo_ready_o (fifo_ready_o),
    .pc_write_i   (pc_write_i),
    .pc_data_i    (pc_data_i),
    .player_i     (player_i),
    .debug_i      (debug_i),
    .rgb_o        (rgb_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .de_o         (de_o)
  );

  initial begin
    forever #CLK_HALF CLK_VIDEO = ~CLK_VIDEO;
  end

  // Outputs lag their inputs by one edge
  always @(posedge CLK_VIDEO) begin
    exp_valid <= model_valid;
    exp_rgb   <= model_rgb;
    exp_ctrl  <= model_ctrl;
  end

  //////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////

  a_rgb_check: assert property (@(posedge CLK_VIDEO) exp_valid |-> (rgb_o == exp_rgb))
    else begin
      $display("FAIL %s rgb expected %06h actual %06h",
               test_name, $sampled(exp_rgb), $sampled(rgb_o));
      error_count = error_count + 1;
    end

  // de, hsync, vsync in that order
  a_ctrl_check: assert property (@(posedge CLK_VIDEO)
    exp_valid |-> ({de_o, hsync_o, vsync_o} == exp_ctrl))
    else begin
      $display("FAIL %s de/hsync/vsync expected %03b actual %03b",
               test_name, $sampled(exp_ctrl), $sampled({de_o, hsync_o, vsync_o}));
      error_count = error_count + 1;
    end

  // Ready is combinational, same cycle
  a_ready_check: assert property (@(posedge CLK_VIDEO)
    model_ready_valid |-> (fifo_ready_o == model_ready))
    else begin
      $display("FAIL %s fifo_ready expected %0b actual %0b",
               test_name, $sampled(model_ready), $sampled(fifo_ready_o));
      error_count = error_count + 1;
    end

  function automatic video_pkg::rgb888_t expand555(input logic [15:0] p);
    video_pkg::rgb888_t c;
    // Top three bits repeated below each 5-bit channel
    c.red   = {p[14:10], p[14:12]};
    c.green = {p[9:5], p[9:7]};
    c.blue  = {p[4:0], p[4:2]};
    return c;
  endfunction

  //////////////////////////////////////////////////
  // One video cycle: drive inputs, predict outputs
  //////////////////////////////////////////////////

  task automatic drive_cycle(input logic [8:0] h, input logic [8:0] v);
    logic [63:0] wdata;
    logic [31:0] rnd;
    logic [31:0] cap_bits;
    logic [7:0]  level;
    logic        hblank;
    logic        vblank;
    logic        de;
    logic        overlay;
    logic        pop;
    logic        lock_now;
    logic        write;
    int          words;
    int          bit_idx;
    @(posedge CLK_VIDEO);
    #2;
    hblank = (h >= H_ACTIVE);
    vblank = (v >= V_ACTIVE);
    de     = !hblank && !vblank;
    core_sreset     = reset_on;
    timing_i.hcount = h;
    timing_i.vcount = v;
    timing_i.hblank = hblank;
    timing_i.vblank = vblank;
    timing_i.de     = de;
    timing_i.hsync  = (h >= H_SYNC_START) && (h < H_SYNC_END);
    timing_i.vsync  = (v == V_SYNC_LINE);
    debug_i         = debug_on;
    // Reader stops at the ready limit
    words = (pixel_q.size() + video_pkg::PIXELS_PER_WORD - 1) / video_pkg::PIXELS_PER_WORD;
    write = writer_on && !reset_on && (words < video_pkg::FIFO_READY_LIMIT);
    word_write_i = write;
    if (write) begin
      wdata  = {$random(seed), $random(seed)};
      word_i = wdata;
    end
    // PC strobes, plain at frame start or flagged across the flag byte columns
    pc_write_i = 1'b0;
    if (strobe_mode == 1 && h == 9'd0 && v == 9'd0) begin
      rnd        = $random(seed);
      pc_write_i = 1'b1;
      pc_data_i  = {8'h00, rnd[23:0]};
    end else if (strobe_mode == 2 && h < 9'd16 && v < 9'(debug_pkg::OVERLAY_HEIGHT)) begin
      rnd        = $random(seed);
      pc_write_i = 1'b1;
      pc_data_i  = rnd | 32'h0100_0000;
    end
    if (player_random && h == 9'd0) begin
      rnd      = $random(seed);
      player_i = rnd[7:0];
    end
    // Expected outputs
    model_ready       = (words < video_pkg::FIFO_READY_LIMIT);
    model_ready_valid = 1'b1;
    model_valid       = 1'b1;
    overlay  = debug_on && (h < 9'(debug_pkg::OVERLAY_WIDTH))
               && (v < 9'(debug_pkg::OVERLAY_HEIGHT));
    pop      = de && locked_m && (pixel_q.size() > 0) && !reset_on;
    lock_now = hblank && vblank && (pixel_q.size() > 0);
    if (reset_on) begin
      model_rgb  = '0;
      model_ctrl = 3'b000;
    end else begin
      if (overlay) begin
        // Bit 31 at the left edge, two pixels per bit
        cap_bits  = captured_m;
        bit_idx   = 31 - int'(h) / debug_pkg::OVERLAY_PIXELS_PER_BIT;
        level     = cap_bits[bit_idx] ? debug_pkg::OVERLAY_ON : debug_pkg::OVERLAY_OFF;
        model_rgb = {level, level, level};
      end else if (pop) begin
        model_rgb = expand555(pixel_q[0]);
      end else begin
        model_rgb = '0;
      end
      model_ctrl = {de, timing_i.hsync, timing_i.vsync};
    end
    // Model state after the edge
    if (reset_on) begin
      pixel_q.delete();
      locked_m   = 1'b0;
      captured_m = '0;
    end else begin
      if (pop) begin
        void'(pixel_q.pop_front());
      end
      if (lock_now) begin
        locked_m = 1'b1;
      end
      // Lowest 16 bits first
      if (write) begin
        for (int k = 0; k < video_pkg::PIXELS_PER_WORD; k++) begin
          pixel_q.push_back(wdata[16*k +: 16]);
        end
      end
      if (pc_write_i) begin
        captured_m.pc = pc_data_i[23:0];
      end
      captured_m.flags = (pc_write_i && pc_data_i[31:24] != 8'h00) ? debug_pkg::OVERLAY_ON
                                                                     : player_i;
    end
  endtask

  task automatic run_lines(input int first, input int last);
    for (int v = first; v <= last; v++) begin
      for (int h = 0; h < int'(H_TOTAL); h++) begin
        drive_cycle(9'(h), 9'(v));
      end
    end
  endtask

  task automatic begin_test(input string name);
    test_name         = name;
    test_start_errors = error_count;
  endtask

  task automatic end_test();
    int errs;
    errs      = error_count - test_start_errors;
    tests_run = tests_run + 1;
    if (errs == 0) begin
      tests_passed = tests_passed + 1;
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, errs);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    core_sreset  = 1'b1;
    timing_i     = '0;
    word_i       = '0;
    word_write_i = 1'b0;
    pc_write_i   = 1'b0;
    pc_data_i    = '0;
    player_i     = '0;
    debug_i      = 1'b0;

    begin_test("reset");
    repeat (RESET_CYCLES) drive_cycle(H_ACTIVE, 9'd0);
    reset_on = 1'b0;
    repeat (2) drive_cycle(H_ACTIVE, 9'd0);
    end_test();

    // Shown lines without vertical blank, FIFO fills to the limit
    begin_test("pre_lock");
    writer_on = 1'b1;
    run_lines(0, 1);
    end_test();

    // Lock in vertical blank, then drain below the limit
    begin_test("fill_level");
    writer_on = 1'b0;
    run_lines(int'(V_ACTIVE), 13);
    run_lines(0, 1);
    end_test();

    begin_test("order_color");
    writer_on = 1'b1;
    run_lines(2, 13);
    run_lines(0, 13);
    end_test();

    begin_test("overlay");
    debug_on      = 1'b1;
    strobe_mode   = 1;
    player_random = 1'b1;
    run_lines(0, 13);
    end_test();

    // Player byte held at zero so the flag stands out
    begin_test("capture");
    strobe_mode   = 2;
    player_random = 1'b0;
    player_i      = 8'h00;
    run_lines(0, 13);
    end_test();

    repeat (2) drive_cycle(H_ACTIVE, 9'd0);
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_passed, tests_run - tests_passed, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("Watchdog timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* video_output_top.sv */
`timescale 1ns/10ps
`default_nettype none

module video_output_top (
  input  wire                       CLK_VIDEO,
  input  wire                       core_sreset,
  input  wire video_pkg::video_timing_t timing_i,
  input  wire video_pkg::fifo_word_t  word_i,
  input  wire                       word_write_i,
  output logic                      fifo_ready_o,
  input  wire                       pc_write_i,
  input  wire [31:0]                pc_data_i,
  input  wire [7:0]                 player_i,
  input  wire                       debug_i,
  output video_pkg::rgb888_t        rgb_o,
  output logic                      hsync_o,
  output logic                      vsync_o,
  output logic                      de_o
);

  // FIFO to output path
  video_pkg::pixel555_t head_pixel;
  logic                 empty;
  logic                 pop;
  logic                 show_pixel;
  // Overlay
  logic                 overlay_active;
  logic [7:0]           overlay_level;

  //////////////////////////////////////////////////
  // Pixel FIFO and lock
  //////////////////////////////////////////////////

  pixel_fifo u_pixel_fifo (
    .CLK_VIDEO    (CLK_VIDEO),
    .core_sreset  (core_sreset),
    .word_i       (word_i),
    .write_i      (word_write_i),
    .pop_i        (pop),
    .head_pixel_o (head_pixel),
    .empty_o      (empty),
    .ready_o      (fifo_ready_o)
  );

  scan_lock_ctrl u_scan_lock_ctrl (
    .CLK_VIDEO    (CLK_VIDEO),
    .core_sreset  (core_sreset),
    .timing_i     (timing_i),
    .empty_i      (empty),
    .pop_o        (pop),
    .show_pixel_o (show_pixel)
  );

  //////////////////////////////////////////////////
  // Overlay and output registers
  //////////////////////////////////////////////////

  debug_overlay u_debug_overlay (
    .CLK_VIDEO   (CLK_VIDEO),
    .core_sreset (core_sreset),
    .pc_write_i  (pc_write_i),
    .pc_data_i   (pc_data_i),
    .player_i    (player_i),
    .debug_i     (debug_i),
    .timing_i    (timing_i),
    .active_o    (overlay_active),
    .level_o     (overlay_level)
  );

  pixel_out_stage u_pixel_out_stage (
    .CLK_VIDEO        (CLK_VIDEO),
    .core_sreset      (core_sreset),
    .timing_i         (timing_i),
    .pixel_i          (head_pixel),
    .show_pixel_i     (show_pixel),
    .overlay_active_i (overlay_active),
    .overlay_level_i  (overlay_level),
    .rgb_o            (rgb_o),
    .hsync_o          (hsync_o),
    .vsync_o          (vsync_o),
    .de_o             (de_o)
  );

endmodule

`default_nettype wire

/* video_pkg.sv */
`default_nettype none

package video_pkg;

  //////////////////////////////////////////////////
  // Timing from the external generator
  //////////////////////////////////////////////////

  // Beam position plus sync and blanking levels
  typedef struct packed {
    logic [8:0] hcount;
    logic [8:0] vcount;
    logic       hsync;
    logic       vsync;
    logic       hblank;
    logic       vblank;
    logic       de;
  } video_timing_t;

  // RGB555 as stored in the frame buffer, top bit ignored
  typedef struct packed {
    logic       pad;
    logic [4:0] red;
    logic [4:0] green;
    logic [4:0] blue;
  } pixel555_t;

  // Output color after expansion
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  //////////////////////////////////////////////////
  // Pixel FIFO sizing
  //////////////////////////////////////////////////

  localparam int PIXELS_PER_WORD  = 4;
  localparam int FIFO_DEPTH_WORDS = 128;
  // Leaves room for eight words in flight from the reader
  localparam int FIFO_READY_LIMIT = 120;
  localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH_WORDS);
  localparam int FIFO_COUNT_W     = FIFO_PTR_W + 1;
  localparam int PIX_IDX_W        = $clog2(PIXELS_PER_WORD);

  // Element 0 sits in the lowest 16 bits and is shown first
  typedef pixel555_t [PIXELS_PER_WORD-1:0] fifo_word_t;

endpackage

`default_nettype wire
